/* logic/radio_types_pkg.sv */
// Radio front-end control core data types
// Widths of samples, settings addresses, readback words and queue levels
`default_nettype none

package radio_types_pkg;

  // One complex sample, I in [31:16] and Q in [15:0]
  localparam int SAMPLE_W = 32;

  // Settings and readback share one address space width
  localparam int SET_ADDR_W = 8;

  // Readback word is two samples wide
  localparam int RB_WORD_W = 64;

  // Wide enough for 0 up to the full transmit queue depth of 8
  localparam int TX_LEVEL_W = 4;

  typedef logic [SAMPLE_W-1:0] sample_t;

  typedef logic [SET_ADDR_W-1:0] set_addr_t;

  typedef logic [RB_WORD_W-1:0] rb_word_t;

  // Fill level of the transmit sample queue
  typedef logic [TX_LEVEL_W-1:0] tx_level_t;

endpackage

`default_nettype wire

/* logic/radio_regs_pkg.sv */
// Radio front-end control core register map
// Settings write addresses, readback addresses and transmit queue sizing
`default_nettype none

package radio_regs_pkg;

  // Transmit queue depth, kept a power of two so the pointers wrap on their own
  localparam int TX_QUEUE_DEPTH = 8;

  // Queue pointer width
  localparam int TX_PTR_W = $clog2(TX_QUEUE_DEPTH);

  // Settings bus write addresses
  // Scratch register, no effect on the datapath
  localparam radio_types_pkg::set_addr_t SR_TEST = 8'd0;
  // Word driven on tx while no sample is queued
  localparam radio_types_pkg::set_addr_t SR_CODEC_IDLE = 8'd1;
  // Push one sample into the transmit queue
  localparam radio_types_pkg::set_addr_t SR_TX_SAMPLE = 8'd2;
  // Bit 0 selects internal TX to RX loopback
  localparam radio_types_pkg::set_addr_t SR_LOOPBACK = 8'd3;
  localparam radio_types_pkg::set_addr_t SR_LEDS = 8'd4;
  localparam radio_types_pkg::set_addr_t SR_MISC_OUTS = 8'd5;

  // Readback addresses
  // Test register in the low half
  localparam radio_types_pkg::set_addr_t RB_TEST = 8'd0;
  // tx high, last captured rx low
  localparam radio_types_pkg::set_addr_t RB_TXRX = 8'd1;
  // Queue fill level, zero extended
  localparam radio_types_pkg::set_addr_t RB_TX_LEVEL = 8'd2;
  // Receive capture count in the low half
  localparam radio_types_pkg::set_addr_t RB_RX_COUNT = 8'd3;
  // misc_ins high, misc_outs low
  localparam radio_types_pkg::set_addr_t RB_MISC_IO = 8'd4;
  localparam radio_types_pkg::set_addr_t RB_LEDS = 8'd5;

endpackage

`default_nettype wire

/* logic/radio_tx_frontend.sv */
// Transmit front-end of the radio control core
// Holds the codec idle word and a small sample queue, drives tx on each tx_stb
`default_nettype none

module radio_tx_frontend (
  input  logic                       radio_clk,
  input  logic                       arst_n,
  input  logic                       set_stb,
  input  radio_types_pkg::set_addr_t set_addr,
  input  radio_types_pkg::sample_t   set_data,
  input  logic                       tx_stb,
  output radio_types_pkg::sample_t   tx,
  output radio_types_pkg::tx_level_t tx_level
);

  import radio_types_pkg::*;
  import radio_regs_pkg::*;

  sample_t               idle_word;
  sample_t               queue_mem [TX_QUEUE_DEPTH];
  logic [TX_PTR_W-1:0]   wr_ptr;
  logic [TX_PTR_W-1:0]   rd_ptr;
  logic                  queue_empty;
  logic                  queue_full;
  logic                  push_req;
  logic                  do_push;
  logic                  do_pop;

  // Status from the level as it stands before this edge
  assign queue_empty = (tx_level == '0);
  assign queue_full  = (tx_level == tx_level_t'(TX_QUEUE_DEPTH));

  assign push_req = set_stb && (set_addr == SR_TX_SAMPLE);

  // A same-edge push never feeds an empty queue's pop
  assign do_pop = tx_stb && !queue_empty;

  // Full queue still takes a push when a slot frees up on the same edge
  assign do_push = push_req && (!queue_full || do_pop);

  // Idle word register
  always_ff @(posedge radio_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      idle_word <= '0;
    end
    else if (set_stb && (set_addr == SR_CODEC_IDLE))
    begin
      idle_word <= set_data;
    end
  end

  // Sample storage
  always_ff @(posedge radio_clk)
  begin
    if (do_push)
    begin
      queue_mem[wr_ptr] <= set_data;
    end
  end

  // Pointers, level and output register
  always_ff @(posedge radio_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      tx_level <= '0;
      tx       <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop together leave the level alone
      case ({do_push, do_pop})
        2'b10:   tx_level <= tx_level + 1'b1;
        2'b01:   tx_level <= tx_level - 1'b1;
        default: tx_level <= tx_level;
      endcase
      // Oldest sample out, idle word when nothing is waiting
      if (tx_stb)
      begin
        tx <= queue_empty ? idle_word : queue_mem[rd_ptr];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/radio_rx_frontend.sv */
// Receive front-end of the radio control core
// Captures rx, or tx in loopback, on each rx_stb and counts the captures
`default_nettype none

module radio_rx_frontend (
  input  logic                       radio_clk,
  input  logic                       arst_n,
  input  logic                       set_stb,
  input  radio_types_pkg::set_addr_t set_addr,
  input  radio_types_pkg::sample_t   set_data,
  input  logic                       rx_stb,
  input  radio_types_pkg::sample_t   rx,
  input  radio_types_pkg::sample_t   tx,
  output radio_types_pkg::sample_t   rx_last,
  output radio_types_pkg::sample_t   rx_count
);

  import radio_types_pkg::*;
  import radio_regs_pkg::*;

  logic    loopback;
  sample_t capture_src;

  // Loopback takes the transmit output register as it stands
  assign capture_src = loopback ? tx : rx;

  // Loopback flag from bit 0 only
  always_ff @(posedge radio_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      loopback <= 1'b0;
    end
    else if (set_stb && (set_addr == SR_LOOPBACK))
    begin
      loopback <= set_data[0];
    end
  end

  // Last sample and capture count
  always_ff @(posedge radio_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rx_last  <= '0;
      rx_count <= '0;
    end
    else if (rx_stb)
    begin
      rx_last  <= capture_src;
      // Wraps at 32 bits
      rx_count <= rx_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/radio_readback.sv */
// Readback block of the radio control core
// Holds test, LED and misc output registers and answers readbacks one cycle later
`default_nettype none

module radio_readback (
  input  logic                       radio_clk,
  input  logic                       arst_n,
  input  logic                       set_stb,
  input  radio_types_pkg::set_addr_t set_addr,
  input  radio_types_pkg::sample_t   set_data,
  input  logic                       rb_stb,
  input  radio_types_pkg::set_addr_t rb_addr,
  input  radio_types_pkg::sample_t   tx,
  input  radio_types_pkg::tx_level_t tx_level,
  input  radio_types_pkg::sample_t   rx_last,
  input  radio_types_pkg::sample_t   rx_count,
  input  radio_types_pkg::sample_t   misc_ins,
  output logic                       rb_valid,
  output radio_types_pkg::rb_word_t  rb_data,
  output radio_types_pkg::sample_t   leds,
  output radio_types_pkg::sample_t   misc_outs
);

  import radio_types_pkg::*;
  import radio_regs_pkg::*;

  sample_t  test_reg;
  rb_word_t rb_next;

  // Local settings registers
  always_ff @(posedge radio_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      test_reg  <= '0;
      leds      <= '0;
      misc_outs <= '0;
    end
    else if (set_stb)
    begin
      case (set_addr)
        SR_TEST:      test_reg  <= set_data;
        SR_LEDS:      leds      <= set_data;
        SR_MISC_OUTS: misc_outs <= set_data;
        default:      ;
      endcase
    end
  end

  // Readback select, unmapped addresses read as zero
  always_comb
  begin
    case (rb_addr)
      RB_TEST:     rb_next = {sample_t'(0), test_reg};
      RB_TXRX:     rb_next = {tx, rx_last};
      RB_TX_LEVEL: rb_next = rb_word_t'(tx_level);
      RB_RX_COUNT: rb_next = {sample_t'(0), rx_count};
      RB_MISC_IO:  rb_next = {misc_ins, misc_outs};
      RB_LEDS:     rb_next = {sample_t'(0), leds};
      default:     rb_next = '0;
    endcase
  end

  // One cycle response, pipelined so back to back requests all get answered
  // Values are taken before any same-edge settings write lands
  always_ff @(posedge radio_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rb_valid <= 1'b0;
      rb_data  <= '0;
    end
    else
    begin
      rb_valid <= rb_stb;
      if (rb_stb)
      begin
        rb_data <= rb_next;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/radio_core.sv */
// Radio front-end control core top level
// Transmit and receive front-ends side by side, results gathered by the readback block
`default_nettype none

module radio_core (
  input  logic                       radio_clk,
  input  logic                       arst_n,
  input  logic                       set_stb,
  input  radio_types_pkg::set_addr_t set_addr,
  input  radio_types_pkg::sample_t   set_data,
  input  logic                       rb_stb,
  input  radio_types_pkg::set_addr_t rb_addr,
  input  logic                       rx_stb,
  input  radio_types_pkg::sample_t   rx,
  input  logic                       tx_stb,
  input  radio_types_pkg::sample_t   misc_ins,
  output radio_types_pkg::sample_t   tx,
  output logic                       rb_valid,
  output radio_types_pkg::rb_word_t  rb_data,
  output radio_types_pkg::sample_t   leds,
  output radio_types_pkg::sample_t   misc_outs
);

  import radio_types_pkg::*;

  // Front-end results toward readback
  tx_level_t tx_level;
  sample_t   rx_last;
  sample_t   rx_count;

  // Settings bus goes to all three blocks, each decodes its own addresses
  radio_tx_frontend u_tx_frontend (
    .radio_clk (radio_clk),
    .arst_n    (arst_n),
    .set_stb   (set_stb),
    .set_addr  (set_addr),
    .set_data  (set_data),
    .tx_stb    (tx_stb),
    .tx        (tx),
    .tx_level  (tx_level)
  );

  // tx also feeds the loopback path
  radio_rx_frontend u_rx_frontend (
    .radio_clk (radio_clk),
    .arst_n    (arst_n),
    .set_stb   (set_stb),
    .set_addr  (set_addr),
    .set_data  (set_data),
    .rx_stb    (rx_stb),
    .rx        (rx),
    .tx        (tx),
    .rx_last   (rx_last),
    .rx_count  (rx_count)
  );

  radio_readback u_readback (
    .radio_clk (radio_clk),
    .arst_n    (arst_n),
    .set_stb   (set_stb),
    .set_addr  (set_addr),
    .set_data  (set_data),
    .rb_stb    (rb_stb),
    .rb_addr   (rb_addr),
    .tx        (tx),
    .tx_level  (tx_level),
    .rx_last   (rx_last),
    .rx_count  (rx_count),
    .misc_ins  (misc_ins),
    .rb_valid  (rb_valid),
    .rb_data   (rb_data),
    .leds      (leds),
    .misc_outs (misc_outs)
  );

endmodule

`default_nettype wire

/* dv/radio_core_model.svh */
// Reference model of the radio control core
// Mirrors every register and the transmit queue, stepped once per rising edge
`ifndef RADIO_CORE_MODEL_SVH
`define RADIO_CORE_MODEL_SVH

// Mirrored registers
sample_t  m_test;
sample_t  m_idle;
sample_t  m_leds;
sample_t  m_misc_outs;
logic     m_loopback;
sample_t  m_tx;
sample_t  m_rx_last;
sample_t  m_rx_count;
// Oldest sample at the front
sample_t  m_queue [$];
// One-deep slot for the readback answer due next cycle
logic     m_rb_pending;
rb_word_t m_rb_word;

function automatic void model_reset();
  m_test       = '0;
  m_idle       = '0;
  m_leds       = '0;
  m_misc_outs  = '0;
  m_loopback   = 1'b0;
  m_tx         = '0;
  m_rx_last    = '0;
  m_rx_count   = '0;
  m_rb_pending = 1'b0;
  m_rb_word    = '0;
  m_queue.delete();
endfunction

// Readback word from the state as it stands before the edge
function automatic rb_word_t model_readback(input set_addr_t addr, input sample_t ins);
  case (addr)
    RB_TEST:     return {32'h0, m_test};
    RB_TXRX:     return {m_tx, m_rx_last};
    RB_TX_LEVEL: return rb_word_t'(m_queue.size());
    RB_RX_COUNT: return {32'h0, m_rx_count};
    RB_MISC_IO:  return {ins, m_misc_outs};
    RB_LEDS:     return {32'h0, m_leds};
    default:     return '0;
  endcase
endfunction

// One rising edge, every update sees the old register values
function automatic void model_step(
  input logic s_stb, input set_addr_t s_addr, input sample_t s_data,
  input logic r_stb, input set_addr_t r_addr,
  input logic rx_s, input sample_t rx_in,
  input logic tx_s, input sample_t ins);
  sample_t old_tx;
  old_tx       = m_tx;
  m_rb_pending = r_stb;
  if (r_stb)
    m_rb_word = model_readback(r_addr, ins);
  // Capture before tx moves, loopback takes the old tx
  if (rx_s)
  begin
    m_rx_last  = m_loopback ? old_tx : rx_in;
    m_rx_count = m_rx_count + 32'd1;
  end
  // Pop first, so a push into an empty queue is not seen on this edge
  if (tx_s)
  begin
    if (m_queue.size() == 0)
      m_tx = m_idle;
    else
      m_tx = m_queue.pop_front();
  end
  if (s_stb)
  begin
    case (s_addr)
      SR_TEST:       m_test = s_data;
      SR_CODEC_IDLE: m_idle = s_data;
      // Full queue drops the sample unless a pop made room
      SR_TX_SAMPLE:  if (m_queue.size() < TX_QUEUE_DEPTH) m_queue.push_back(s_data);
      SR_LOOPBACK:   m_loopback = s_data[0];
      SR_LEDS:       m_leds = s_data;
      SR_MISC_OUTS:  m_misc_outs = s_data;
      default:       ;
    endcase
  end
endfunction

`endif

/* dv/radio_core_tb.sv */
// Testbench for the radio control core
// Random strobes and settings from an LFSR, checked against a model every cycle
`default_nettype none

module radio_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import radio_types_pkg::*;
  import radio_regs_pkg::*;

  localparam int N_OPS          = 3000;
  // Reset and the final flush fit easily in twice the op count
  localparam int TIMEOUT_CYCLES = 2 * N_OPS;
  // No register decodes this one
  localparam set_addr_t UNUSED_ADDR = 8'h3c;

  logic      radio_clk;
  logic      arst_n;
  logic      set_stb;
  set_addr_t set_addr;
  sample_t   set_data;
  logic      rb_stb;
  set_addr_t rb_addr;
  logic      rx_stb;
  sample_t   rx;
  logic      tx_stb;
  sample_t   misc_ins;
  sample_t   tx;
  logic      rb_valid;
  rb_word_t  rb_data;
  sample_t   leds;
  sample_t   misc_outs;

  logic [31:0] lfsr_state;
  int          value_errors;
  int          protocol_errors;
  int          cycle_count;

  `include "radio_core_model.svh"

  radio_core DUT (.*);

  initial
  begin
    radio_clk = 1'b0;
    forever #20 radio_clk = ~radio_clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic next_bit();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val = {val[30:0], next_bit()};
    end
    return val;
  endfunction

  task automatic compare_value(input string name, input rb_word_t actual,
                               input rb_word_t expected);
    assert (actual === expected)
    else
    begin
      value_errors++;
      $display("** Error: %0s = 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_outputs();
    compare_value("tx", rb_word_t'(tx), rb_word_t'(m_tx));
    compare_value("leds", rb_word_t'(leds), rb_word_t'(m_leds));
    compare_value("misc_outs", rb_word_t'(misc_outs), rb_word_t'(m_misc_outs));
    // rb_valid exactly one cycle after each rb_stb
    assert (rb_valid === m_rb_pending)
    else
    begin
      protocol_errors++;
      if (rb_valid === 1'b1)
        $display("rb_valid came without a readback request");
      else
        $display("Readback request got no rb_valid one cycle later");
    end
    if (rb_valid === 1'b1 && m_rb_pending)
      compare_value("rb_data", rb_data, m_rb_word);
  endtask

  task automatic drive_random(input int op);
    logic [31:0] a;
    set_stb = next_bit();
    a       = take_bits(4);
    // Half of all writes push samples so the queue fills up
    if (a < 8)
      set_addr = SR_TX_SAMPLE;
    else if (a < 14)
      set_addr = set_addr_t'(a - 8);
    else
      set_addr = UNUSED_ADDR;
    set_data = take_bits(32);
    rb_stb   = next_bit();
    a        = take_bits(3);
    rb_addr  = (a < 6) ? set_addr_t'(a) : UNUSED_ADDR;
    rx_stb   = next_bit();
    rx       = take_bits(32);
    // Slow tx phases let the queue fill, fast ones drain it to idle
    if ((op % 400) < 200)
      tx_stb = (take_bits(3) == 0);
    else
      tx_stb = next_bit();
    misc_ins = take_bits(32);
  endtask

  // Model after the DUT edge, check at the falling edge
  task automatic run_cycle();
    @(posedge radio_clk);
    model_step(set_stb, set_addr, set_data, rb_stb, rb_addr, rx_stb, rx, tx_stb, misc_ins);
    @(negedge radio_clk);
    check_outputs();
  endtask

  initial
  begin
    lfsr_state      = 32'd29;
    value_errors    = 0;
    protocol_errors = 0;
    arst_n          = 1'b0;
    set_stb         = 1'b0;
    set_addr        = '0;
    set_data        = '0;
    rb_stb          = 1'b0;
    rb_addr         = '0;
    rx_stb          = 1'b0;
    rx              = '0;
    tx_stb          = 1'b0;
    misc_ins        = '0;
    model_reset();
    repeat (4) @(posedge radio_clk);
    @(negedge radio_clk);
    arst_n = 1'b1;
    // All outputs zero straight out of reset
    check_outputs();
    compare_value("rb_data", rb_data, '0);
    for (int op = 0; op < N_OPS; op++)
    begin
      drive_random(op);
      run_cycle();
    end
    // Quiet cycle to collect the last readback
    set_stb = 1'b0;
    rb_stb  = 1'b0;
    rx_stb  = 1'b0;
    tx_stb  = 1'b0;
    run_cycle();
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge radio_clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the test sequence never finished", cycle_count);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* radio_core.f */
+incdir+dv
logic/radio_types_pkg.sv
logic/radio_regs_pkg.sv
logic/radio_tx_frontend.sv
logic/radio_rx_frontend.sv
logic/radio_readback.sv
logic/radio_core.sv
dv/radio_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the radio core testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module radio_core_tb -f radio_core.f \
  && ./obj_dir/Vradio_core_tb 2>&1 | tee sim.log \
  && grep -q "^Simulation PASSED$" sim.log \
  && echo "Run passed, log in sim.log" \
  || { echo "Run failed, see sim.log"; exit 1; }
